/* common/rosetta_pkg.sv */
/*
 * Shared definitions for the sparse vector core
 *   Lane and word defaults, memory pointer widths
 *   Opcode encoding and instruction word layout
 *   Context passed from stage to stage
 */

package rosetta_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    // Default lane count, power of two
    localparam int LANES_DEF = 16;
    // Default lane word width
    localparam int WORD_DEF  = 8;

    localparam int INST_W    = 28;
    localparam int PC_W      = 8;
    // 16 vector and mask entries
    localparam int VPTR_W    = 4;
    // Multiply result shift
    localparam int FP_W      = 2;

    // --------------------------------------------------
    // Instruction encoding
    // --------------------------------------------------
    typedef enum logic [1:0] {
        OP_ADD  = 2'd0,
        OP_SUB  = 2'd1,
        OP_MUL  = 2'd2,
        OP_HALT = 2'd3
    } opcode_t;

    // Destination on top, reserved bits at the bottom
    typedef struct packed {
        logic [VPTR_W-1:0] dst_ptr;
        logic [VPTR_W-1:0] src0_ptr;
        logic [VPTR_W-1:0] src1_ptr;
        opcode_t           op;
        logic [FP_W-1:0]   fp_shift;
        logic [11:0]       unused;
    } inst_t;

    // --------------------------------------------------
    // Stage context
    // --------------------------------------------------
    // Travels down the pipe with each instruction
    typedef struct packed {
        logic              valid;
        logic              halt;
        opcode_t           op;
        logic [FP_W-1:0]   fp_shift;
        logic [VPTR_W-1:0] dst_ptr;
    } stage_ctx_t;

endpackage

/* frontend/rosetta_fetch_decode.sv */
/*
 * Fetch and decode stages
 *   Program counter and halt tracking
 *   DEC valid bit and mask read issue
 *   Context register toward MSK
 */

`timescale 1ns/10ps

module rosetta_fetch_decode (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [rosetta_pkg::INST_W-1:0]   im_rdata,
    output logic                             im_ren,
    output logic [rosetta_pkg::PC_W-1:0]     im_ptr,
    output logic                             pam_src0_ren,
    output logic [rosetta_pkg::VPTR_W-1:0]   pam_src0_ptr,
    output logic                             pam_src1_ren,
    output logic [rosetta_pkg::VPTR_W-1:0]   pam_src1_ptr,
    output rosetta_pkg::stage_ctx_t          ctx_dec
);

    logic [rosetta_pkg::PC_W-1:0] pc;
    logic                         started;
    logic                         halted;
    logic                         dec_valid;
    logic                         dec_halt;
    logic                         dec_issue;
    rosetta_pkg::inst_t           dec_inst;

    // --------------------------------------------------
    // IF
    // --------------------------------------------------
    // Low for one cycle after reset, then fetch until halt
    assign im_ren = started & ~halted;
    assign im_ptr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= '0;
            started <= 1'b0;
        end else begin
            started <= 1'b1;
            if (im_ren) begin
                pc <= pc + 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // DEC
    // --------------------------------------------------
    // Word returned by the synchronous instruction memory
    assign dec_inst  = rosetta_pkg::inst_t'(im_rdata);
    assign dec_halt  = dec_valid & (dec_inst.op == rosetta_pkg::OP_HALT);
    assign dec_issue = dec_valid & ~dec_halt;

    assign pam_src0_ren = dec_issue;
    assign pam_src0_ptr = dec_inst.src0_ptr;
    assign pam_src1_ren = dec_issue;
    assign pam_src1_ptr = dec_inst.src1_ptr;

    // The fetch behind a halt in DEC is squashed here
    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
            halted    <= 1'b0;
        end else begin
            dec_valid <= im_ren & ~dec_halt;
            if (dec_halt) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctx_dec <= '0;
        end else begin
            ctx_dec.valid    <= dec_valid;
            ctx_dec.halt     <= dec_halt;
            ctx_dec.op       <= dec_inst.op;
            ctx_dec.fp_shift <= dec_inst.fp_shift;
            ctx_dec.dst_ptr  <= dec_inst.dst_ptr;
        end
    end

    // Once halted, nothing new is fetched or decoded
    a_fetch_stays_off : assert property (
        @(posedge clk) disable iff (rst)
        halted |-> (!im_ren && !dec_valid)
    );

endmodule

/* source/rosetta_core.sv */
/*
 * Sparse vector core top level
 *   Fetch/decode, mask, vector unit and write stages
 *   Connects the stages to the external memory ports
 */

`timescale 1ns/10ps

module rosetta_core #(
    parameter int LANES = rosetta_pkg::LANES_DEF,
    parameter int WORD  = rosetta_pkg::WORD_DEF
) (
    input  logic                             clk,
    input  logic                             rst,

    // Instruction memory
    output logic                             im_ren,
    output logic [rosetta_pkg::PC_W-1:0]     im_ptr,
    input  logic [rosetta_pkg::INST_W-1:0]   im_rdata,

    // Mask memory reads
    output logic                             pam_src0_ren,
    output logic [rosetta_pkg::VPTR_W-1:0]   pam_src0_ptr,
    input  logic [LANES-1:0]                 pam_src0_rdata,
    output logic                             pam_src1_ren,
    output logic [rosetta_pkg::VPTR_W-1:0]   pam_src1_ptr,
    input  logic [LANES-1:0]                 pam_src1_rdata,

    // Activation memory reads
    output logic                             am_src0_ren,
    output logic [rosetta_pkg::VPTR_W-1:0]   am_src0_ptr,
    output logic [LANES-1:0]                 am_src0_cs,
    input  logic [LANES*WORD-1:0]            am_src0_rdata,
    output logic                             am_src1_ren,
    output logic [rosetta_pkg::VPTR_W-1:0]   am_src1_ptr,
    output logic [LANES-1:0]                 am_src1_cs,
    input  logic [LANES*WORD-1:0]            am_src1_rdata,

    // Destination writes
    output logic                             pam_dst_wen,
    output logic [rosetta_pkg::VPTR_W-1:0]   pam_dst_ptr,
    output logic [LANES-1:0]                 pam_dst_wdata,
    output logic                             am_dst_wen,
    output logic [rosetta_pkg::VPTR_W-1:0]   am_dst_ptr,
    output logic [LANES-1:0]                 am_dst_cs,
    output logic [LANES*WORD-1:0]            am_dst_wdata,

    output logic                             done
);

    rosetta_pkg::stage_ctx_t ctx_dec;
    rosetta_pkg::stage_ctx_t ctx_msk;
    rosetta_pkg::stage_ctx_t ctx_com;
    logic [LANES-1:0]        lane_sel_msk;
    logic [LANES-1:0]        lane_sel_com;
    logic [LANES*WORD-1:0]   result;
    logic [LANES-1:0]        nz_mask;

    // IF and DEC
    rosetta_fetch_decode u_fetch_decode (
        .clk          (clk),
        .rst          (rst),
        .im_rdata     (im_rdata),
        .im_ren       (im_ren),
        .im_ptr       (im_ptr),
        .pam_src0_ren (pam_src0_ren),
        .pam_src0_ptr (pam_src0_ptr),
        .pam_src1_ren (pam_src1_ren),
        .pam_src1_ptr (pam_src1_ptr),
        .ctx_dec      (ctx_dec)
    );

    // MSK
    rosetta_mask_stage #(
        .LANES (LANES)
    ) u_mask_stage (
        .clk            (clk),
        .rst            (rst),
        .ctx_dec        (ctx_dec),
        .pam_src0_ptr   (pam_src0_ptr),
        .pam_src1_ptr   (pam_src1_ptr),
        .pam_src0_rdata (pam_src0_rdata),
        .pam_src1_rdata (pam_src1_rdata),
        .am_src0_ren    (am_src0_ren),
        .am_src0_ptr    (am_src0_ptr),
        .am_src0_cs     (am_src0_cs),
        .am_src1_ren    (am_src1_ren),
        .am_src1_ptr    (am_src1_ptr),
        .am_src1_cs     (am_src1_cs),
        .ctx_msk        (ctx_msk),
        .lane_sel_msk   (lane_sel_msk)
    );

    // RM and COM
    rosetta_vector_unit #(
        .LANES (LANES),
        .WORD  (WORD)
    ) u_vector_unit (
        .clk           (clk),
        .rst           (rst),
        .ctx_msk       (ctx_msk),
        .lane_sel_msk  (lane_sel_msk),
        .am_src0_rdata (am_src0_rdata),
        .am_src1_rdata (am_src1_rdata),
        .ctx_com       (ctx_com),
        .lane_sel_com  (lane_sel_com),
        .result        (result),
        .nz_mask       (nz_mask)
    );

    // WM
    rosetta_writeback #(
        .LANES (LANES),
        .WORD  (WORD)
    ) u_writeback (
        .clk           (clk),
        .rst           (rst),
        .ctx_com       (ctx_com),
        .lane_sel_com  (lane_sel_com),
        .result        (result),
        .nz_mask       (nz_mask),
        .am_dst_wen    (am_dst_wen),
        .am_dst_ptr    (am_dst_ptr),
        .am_dst_cs     (am_dst_cs),
        .am_dst_wdata  (am_dst_wdata),
        .pam_dst_wen   (pam_dst_wen),
        .pam_dst_ptr   (pam_dst_ptr),
        .pam_dst_wdata (pam_dst_wdata),
        .done          (done)
    );

endmodule

/* source/rosetta_mask_stage.sv */
/*
 * Mask stage
 *   Lane select from the two source masks
 *   Vector read issue with lane chip select
 */

`timescale 1ns/10ps

module rosetta_mask_stage #(
    parameter int LANES = rosetta_pkg::LANES_DEF
) (
    input  logic                             clk,
    input  logic                             rst,
    input  rosetta_pkg::stage_ctx_t          ctx_dec,
    input  logic [rosetta_pkg::VPTR_W-1:0]   pam_src0_ptr,
    input  logic [rosetta_pkg::VPTR_W-1:0]   pam_src1_ptr,
    input  logic [LANES-1:0]                 pam_src0_rdata,
    input  logic [LANES-1:0]                 pam_src1_rdata,
    output logic                             am_src0_ren,
    output logic [rosetta_pkg::VPTR_W-1:0]   am_src0_ptr,
    output logic [LANES-1:0]                 am_src0_cs,
    output logic                             am_src1_ren,
    output logic [rosetta_pkg::VPTR_W-1:0]   am_src1_ptr,
    output logic [LANES-1:0]                 am_src1_cs,
    output rosetta_pkg::stage_ctx_t          ctx_msk,
    output logic [LANES-1:0]                 lane_sel_msk
);

    logic [rosetta_pkg::VPTR_W-1:0] src0_ptr_q;
    logic [rosetta_pkg::VPTR_W-1:0] src1_ptr_q;
    logic                           rd_en;
    logic [LANES-1:0]               lane_sel;

    // Vector pointers follow their mask pointers by one cycle
    always_ff @(posedge clk) begin
        src0_ptr_q <= pam_src0_ptr;
        src1_ptr_q <= pam_src1_ptr;
    end

    assign rd_en    = ctx_dec.valid & ~ctx_dec.halt;
    // Lanes present in both sources
    assign lane_sel = rd_en ? (pam_src0_rdata & pam_src1_rdata) : '0;

    assign am_src0_ren = rd_en;
    assign am_src0_ptr = src0_ptr_q;
    assign am_src0_cs  = lane_sel;
    assign am_src1_ren = rd_en;
    assign am_src1_ptr = src1_ptr_q;
    assign am_src1_cs  = lane_sel;

    // --------------------------------------------------
    // MSK to RM
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ctx_msk      <= '0;
            lane_sel_msk <= '0;
        end else begin
            ctx_msk      <= ctx_dec;
            lane_sel_msk <= lane_sel;
        end
    end

    // The slot behind a halt never reads the vectors
    a_no_read_after_halt : assert property (
        @(posedge clk) disable iff (rst)
        (ctx_dec.valid && ctx_dec.halt) |=> (!am_src0_ren && !am_src1_ren)
    );

endmodule

/* source/rosetta_writeback.sv */
/*
 * Write stage
 *   Destination vector and mask write strobes
 *   Done flag set by the halt
 */

`timescale 1ns/10ps

module rosetta_writeback #(
    parameter int LANES = rosetta_pkg::LANES_DEF,
    parameter int WORD  = rosetta_pkg::WORD_DEF
) (
    input  logic                             clk,
    input  logic                             rst,
    input  rosetta_pkg::stage_ctx_t          ctx_com,
    input  logic [LANES-1:0]                 lane_sel_com,
    input  logic [LANES*WORD-1:0]            result,
    input  logic [LANES-1:0]                 nz_mask,
    output logic                             am_dst_wen,
    output logic [rosetta_pkg::VPTR_W-1:0]   am_dst_ptr,
    output logic [LANES-1:0]                 am_dst_cs,
    output logic [LANES*WORD-1:0]            am_dst_wdata,
    output logic                             pam_dst_wen,
    output logic [rosetta_pkg::VPTR_W-1:0]   pam_dst_ptr,
    output logic [LANES-1:0]                 pam_dst_wdata,
    output logic                             done
);

    logic wr;

    assign wr = ctx_com.valid & ~ctx_com.halt;

    // Vector and mask share pointer and strobe
    assign am_dst_wen    = wr;
    assign am_dst_ptr    = ctx_com.dst_ptr;
    // Lane select is already zero for idle and halt slots
    assign am_dst_cs     = lane_sel_com;
    assign am_dst_wdata  = result;
    assign pam_dst_wen   = wr;
    assign pam_dst_ptr   = ctx_com.dst_ptr;
    assign pam_dst_wdata = nz_mask;

    // Sticky until reset
    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else if (ctx_com.valid && ctx_com.halt) begin
            done <= 1'b1;
        end
    end

    a_cs_idle : assert property (
        @(posedge clk) disable iff (rst)
        !am_dst_wen |-> (am_dst_cs == '0)
    );

    // Nothing may follow the halt down the pipe
    a_quiet_after_done : assert property (
        @(posedge clk) disable iff (rst)
        done |-> (!am_dst_wen ##1 done)
    );

endmodule

/* src.f */
common/rosetta_pkg.sv
vector_unit/rosetta_lane_alu.sv
vector_unit/rosetta_vector_unit.sv
frontend/rosetta_fetch_decode.sv
source/rosetta_mask_stage.sv
source/rosetta_writeback.sv
source/rosetta_core.sv
testbench/rosetta_tb.sv

/* testbench/rosetta_tb.sv */
/*
 * Testbench for the sparse vector core
 *   Instruction, mask and vector memory models
 *   Random program with source spacing, ending in a halt
 *   In-order reference model, write and final memory checks
 */

`timescale 1ns/10ps

module rosetta_tb;

    localparam int LANES    = rosetta_pkg::LANES_DEF;
    localparam int WORD     = rosetta_pkg::WORD_DEF;
    localparam int VW       = LANES * WORD;
    localparam int NUM_INST = 40;
    localparam int LIMIT    = 400;

    typedef struct packed {
        logic [rosetta_pkg::VPTR_W-1:0] src0;
        logic [rosetta_pkg::VPTR_W-1:0] src1;
        logic [LANES-1:0]               sel;
    } read_rec_t;

    typedef struct packed {
        logic [rosetta_pkg::PC_W-1:0]   idx;
        logic [rosetta_pkg::VPTR_W-1:0] dst;
        logic [LANES-1:0]               sel;
        logic [VW-1:0]                  data;
        logic [LANES-1:0]               nz;
    } write_rec_t;

    logic clk;
    logic rst;
    logic im_ren, pam_src0_ren, pam_src1_ren, am_src0_ren, am_src1_ren;
    logic am_dst_wen, pam_dst_wen, done;
    logic [rosetta_pkg::PC_W-1:0]   im_ptr;
    logic [rosetta_pkg::INST_W-1:0] im_rdata;
    logic [rosetta_pkg::VPTR_W-1:0] pam_src0_ptr, pam_src1_ptr, am_src0_ptr, am_src1_ptr;
    logic [rosetta_pkg::VPTR_W-1:0] am_dst_ptr, pam_dst_ptr;
    logic [LANES-1:0] pam_src0_rdata, pam_src1_rdata, am_src0_cs, am_src1_cs;
    logic [LANES-1:0] am_dst_cs, pam_dst_wdata;
    logic [VW-1:0]    am_src0_rdata, am_src1_rdata, am_dst_wdata;

    // Memories seen by the DUT and the model's copies
    logic [rosetta_pkg::INST_W-1:0] imem [0:255];
    logic [VW-1:0]                  vmem [0:15];
    logic [LANES-1:0]               mmem [0:15];
    logic [VW-1:0]                  ref_vmem [0:15];
    logic [LANES-1:0]               ref_mmem [0:15];
    rosetta_pkg::inst_t             prog [0:NUM_INST];

    read_rec_t   rd_q[$];
    write_rec_t  wr_q[$];
    int          cycle = 0;
    int          fetch_cycle [0:255];
    int          fetch_count = 0;
    int          mask_count = 0;
    bit          done_seen = 1'b0;
    bit          reset_checked = 1'b0;
    int          seed = 32'hdac4b9f7;
    int unsigned rnd;

    rosetta_core #(
        .LANES (LANES),
        .WORD  (WORD)
    ) u_rosetta_core (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // --------------------------------------------------
    // Error reporting
    // --------------------------------------------------
    task automatic stop_run();
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_error(input string what);
        $display("ERROR: %s", what);
        stop_run();
    endtask

    task automatic check_value(input string name, input logic [VW-1:0] got,
                               input logic [VW-1:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    // --------------------------------------------------
    // Memory models, one cycle read latency
    // --------------------------------------------------
    function automatic logic [VW-1:0] lane_merge(input logic [VW-1:0] old_word,
                                                 input logic [VW-1:0] new_word,
                                                 input logic [LANES-1:0] cs);
        logic [VW-1:0] out;
        out = old_word;
        for (int i = 0; i < LANES; i++) begin
            if (cs[i]) begin
                out[i*WORD +: WORD] = new_word[i*WORD +: WORD];
            end
        end
        return out;
    endfunction

    always @(posedge clk) begin
        if (im_ren) begin
            im_rdata <= imem[im_ptr];
        end
        if (pam_src0_ren) begin
            pam_src0_rdata <= mmem[pam_src0_ptr];
        end
        if (pam_src1_ren) begin
            pam_src1_rdata <= mmem[pam_src1_ptr];
        end
        // Deselected read lanes come back as zero
        if (am_src0_ren) begin
            am_src0_rdata <= lane_merge('0, vmem[am_src0_ptr], am_src0_cs);
        end
        if (am_src1_ren) begin
            am_src1_rdata <= lane_merge('0, vmem[am_src1_ptr], am_src1_cs);
        end
        if (am_dst_wen) begin
            vmem[am_dst_ptr] <= lane_merge(vmem[am_dst_ptr], am_dst_wdata, am_dst_cs);
        end
        if (pam_dst_wen) begin
            mmem[pam_dst_ptr] <= pam_dst_wdata;
        end
    end

    // --------------------------------------------------
    // Program and reference model
    // --------------------------------------------------
    function automatic logic [WORD-1:0] clamp_word(input int v);
        int hi;
        int lo;
        hi = (1 << (WORD - 1)) - 1;
        lo = -(1 << (WORD - 1));
        if (v > hi) begin
            return WORD'(hi);
        end
        if (v < lo) begin
            return WORD'(lo);
        end
        return WORD'(v);
    endfunction

    function automatic logic [WORD-1:0] lane_model(input rosetta_pkg::opcode_t op,
                                                   input logic [WORD-1:0] a,
                                                   input logic [WORD-1:0] b, input int sh);
        int sa;
        int sb;
        sa = $signed(a);
        sb = $signed(b);
        case (op)
            rosetta_pkg::OP_ADD: return clamp_word(sa + sb);
            rosetta_pkg::OP_SUB: return clamp_word(sa - sb);
            default:             return clamp_word((sa * sb) >>> sh);
        endcase
    endfunction

    // True if one of the four previous instructions writes this entry
    function automatic bit written_recently(input int k, input logic [3:0] p);
        for (int d = 1; d <= 4; d++) begin
            if (k - d >= 0 && prog[k-d].dst_ptr == p) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic logic [3:0] pick_source(input int k);
        logic [3:0] p;
        p = $urandom_range(0, 15);
        while (written_recently(k, p)) begin
            p = $urandom_range(0, 15);
        end
        return p;
    endfunction

    task automatic fill_memories();
        for (int p = 0; p < 16; p++) begin
            mmem[p] = $urandom;
            // About a quarter of the words are zero
            for (int i = 0; i < LANES; i++) begin
                vmem[p][i*WORD +: WORD] = ($urandom_range(0, 3) == 0) ? '0 : $urandom;
            end
            ref_vmem[p] = vmem[p];
            ref_mmem[p] = mmem[p];
        end
    endtask

    task automatic build_program();
        rosetta_pkg::inst_t inst;
        for (int k = 0; k < NUM_INST; k++) begin
            inst.dst_ptr  = $urandom_range(0, 15);
            inst.src0_ptr = pick_source(k);
            inst.src1_ptr = pick_source(k);
            inst.op       = rosetta_pkg::opcode_t'($urandom_range(0, 2));
            inst.fp_shift = $urandom_range(0, 3);
            inst.unused   = $urandom;
            prog[k] = inst;
        end
        inst.op = rosetta_pkg::OP_HALT;
        prog[NUM_INST] = inst;
        for (int a = 0; a < 256; a++) begin
            if (a <= NUM_INST) begin
                imem[a] = prog[a];
            end else begin
                imem[a] = {a[7:0], a[7:0], a[7:0], a[3:0]};
            end
        end
    endtask

    task automatic run_model();
        rosetta_pkg::inst_t inst;
        read_rec_t          rd;
        write_rec_t         wr;
        logic [WORD-1:0]    y;
        for (int k = 0; k < NUM_INST; k++) begin
            inst    = prog[k];
            rd.src0 = inst.src0_ptr;
            rd.src1 = inst.src1_ptr;
            rd.sel  = ref_mmem[inst.src0_ptr] & ref_mmem[inst.src1_ptr];
            wr.idx  = k;
            wr.dst  = inst.dst_ptr;
            wr.sel  = rd.sel;
            wr.data = '0;
            wr.nz   = '0;
            for (int i = 0; i < LANES; i++) begin
                if (rd.sel[i]) begin
                    y = lane_model(inst.op, ref_vmem[inst.src0_ptr][i*WORD +: WORD],
                                   ref_vmem[inst.src1_ptr][i*WORD +: WORD], inst.fp_shift);
                    wr.data[i*WORD +: WORD] = y;
                    wr.nz[i] = (y != '0);
                end
            end
            ref_vmem[inst.dst_ptr] = lane_merge(ref_vmem[inst.dst_ptr], wr.data, wr.sel);
            ref_mmem[inst.dst_ptr] = wr.nz;
            rd_q.push_back(rd);
            wr_q.push_back(wr);
        end
    endtask

    // --------------------------------------------------
    // Output monitor, sampled mid-cycle
    // --------------------------------------------------
    task automatic check_reset_state();
        check_value("im_ren", im_ren, 0);
        check_value("pam_src0_ren", pam_src0_ren, 0);
        check_value("pam_src1_ren", pam_src1_ren, 0);
        check_value("am_src0_ren", am_src0_ren, 0);
        check_value("am_dst_wen", am_dst_wen, 0);
        check_value("pam_dst_wen", pam_dst_wen, 0);
        check_value("am_dst_cs", am_dst_cs, 0);
        check_value("done", done, 0);
    endtask

    // Mask reads go out one cycle after the fetch
    task automatic check_mask_read();
        assert (mask_count < NUM_INST) else report_error("mask read with no instruction in DEC");
        check_value("pam_src0_ren", pam_src0_ren, 1);
        check_value("pam_src1_ren", pam_src1_ren, 1);
        check_value("pam_src0_ptr", pam_src0_ptr, prog[mask_count].src0_ptr);
        check_value("pam_src1_ptr", pam_src1_ptr, prog[mask_count].src1_ptr);
        check_value("mask read cycle", cycle, fetch_cycle[mask_count] + 1);
        mask_count++;
    endtask

    task automatic check_read();
        read_rec_t rd;
        assert (rd_q.size() > 0) else report_error("vector read with no instruction in flight");
        rd = rd_q.pop_front();
        check_value("am_src0_ren", am_src0_ren, 1);
        check_value("am_src1_ren", am_src1_ren, 1);
        check_value("am_src0_ptr", am_src0_ptr, rd.src0);
        check_value("am_src1_ptr", am_src1_ptr, rd.src1);
        check_value("am_src0_cs", am_src0_cs, rd.sel);
        check_value("am_src1_cs", am_src1_cs, rd.sel);
    endtask

    task automatic check_write();
        write_rec_t wr;
        assert (wr_q.size() > 0) else report_error("write with no instruction in flight");
        wr = wr_q.pop_front();
        check_value("am_dst_wen", am_dst_wen, 1);
        check_value("pam_dst_wen", pam_dst_wen, 1);
        check_value("am_dst_ptr", am_dst_ptr, wr.dst);
        check_value("pam_dst_ptr", pam_dst_ptr, wr.dst);
        check_value("am_dst_cs", am_dst_cs, wr.sel);
        check_value("am_dst_wdata", am_dst_wdata, wr.data);
        check_value("pam_dst_wdata", pam_dst_wdata, wr.nz);
        // Five cycles from fetch to write
        check_value("write cycle", cycle, fetch_cycle[wr.idx] + 5);
    endtask

    always @(negedge clk) begin
        if (rst || !reset_checked) begin
            check_reset_state();
            reset_checked = !rst;
        end else begin
            if (im_ren) begin
                assert (!done_seen) else report_error("fetch resumed after done");
                assert (fetch_count <= NUM_INST + 1) else report_error("fetch ran past the halt");
                check_value("im_ptr", im_ptr, fetch_count);
                fetch_cycle[im_ptr] = cycle;
                fetch_count++;
            end
            if (pam_src0_ren || pam_src1_ren) begin
                check_mask_read();
            end
            if (am_src0_ren || am_src1_ren) begin
                check_read();
            end
            if (am_dst_wen || pam_dst_wen) begin
                check_write();
            end else begin
                check_value("am_dst_cs", am_dst_cs, 0);
            end
            if (done_seen) begin
                check_value("done", done, 1);
            end else if (done) begin
                check_value("done cycle", cycle, fetch_cycle[NUM_INST] + 6);
                done_seen = 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    task automatic wait_for_done();
        int n;
        n = 0;
        while (!done && n < LIMIT) begin
            @(posedge clk);
            n++;
        end
        assert (done) else report_error("timeout while waiting for done");
    endtask

    task automatic check_final();
        for (int p = 0; p < 16; p++) begin
            check_value($sformatf("vector_mem[%0d]", p), vmem[p], ref_vmem[p]);
            check_value($sformatf("mask_mem[%0d]", p), mmem[p], ref_mmem[p]);
        end
        assert (rd_q.size() == 0 && wr_q.size() == 0)
            else report_error("some instructions never reached the write stage");
        check_value("fetch count", fetch_count, NUM_INST + 2);
        check_value("mask read count", mask_count, NUM_INST);
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        im_rdata       = '0;
        pam_src0_rdata = '0;
        pam_src1_rdata = '0;
        am_src0_rdata  = '0;
        am_src1_rdata  = '0;
        rnd = $urandom(seed);
        fill_memories();
        build_program();
        run_model();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        wait_for_done();
        repeat (3) @(posedge clk);
        check_final();
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* vector_unit/rosetta_lane_alu.sv */
/*
 * Single lane arithmetic
 *   Saturating signed add and subtract
 *   Fixed-point multiply with right shift
 */

`timescale 1ns/10ps

module rosetta_lane_alu #(
    parameter int WORD = rosetta_pkg::WORD_DEF
) (
    input  logic [WORD-1:0]               a,
    input  logic [WORD-1:0]               b,
    input  rosetta_pkg::opcode_t          op,
    input  logic [rosetta_pkg::FP_W-1:0]  fp_shift,
    output logic [WORD-1:0]               y
);

    localparam int WIDE = 2 * WORD;

    logic signed [WIDE-1:0] a_ext;
    logic signed [WIDE-1:0] b_ext;
    logic signed [WIDE-1:0] sum;
    logic signed [WIDE-1:0] diff;
    logic signed [WIDE-1:0] prod;
    logic signed [WIDE-1:0] prod_shr;
    logic signed [WIDE-1:0] pick;

    // Clamp a double-width value into WORD bits
    function automatic logic [WORD-1:0] saturate(input logic signed [WIDE-1:0] v);
        logic overflow;
        overflow = (v[WIDE-1:WORD-1] != {(WORD+1){v[WIDE-1]}});
        if (!overflow) begin
            return v[WORD-1:0];
        end
        return v[WIDE-1] ? {1'b1, {(WORD-1){1'b0}}} : {1'b0, {(WORD-1){1'b1}}};
    endfunction

    assign a_ext = {{WORD{a[WORD-1]}}, a};
    assign b_ext = {{WORD{b[WORD-1]}}, b};

    assign sum  = a_ext + b_ext;
    assign diff = a_ext - b_ext;
    // Exact at double width
    assign prod = a_ext * b_ext;
    assign prod_shr = prod >>> fp_shift;

    always_comb begin
        case (op)
            rosetta_pkg::OP_ADD: pick = sum;
            rosetta_pkg::OP_SUB: pick = diff;
            rosetta_pkg::OP_MUL: pick = prod_shr;
            default:             pick = '0;
        endcase
    end

    assign y = saturate(pick);

endmodule

/* vector_unit/rosetta_vector_unit.sv */
/*
 * Vector unit, RM and COM stages
 *   Operand register behind the vector reads
 *   Lane ALU array and result register
 *   Nonzero mask of the selected lanes
 */

`timescale 1ns/10ps

module rosetta_vector_unit #(
    parameter int LANES = rosetta_pkg::LANES_DEF,
    parameter int WORD  = rosetta_pkg::WORD_DEF
) (
    input  logic                     clk,
    input  logic                     rst,
    input  rosetta_pkg::stage_ctx_t  ctx_msk,
    input  logic [LANES-1:0]         lane_sel_msk,
    input  logic [LANES*WORD-1:0]    am_src0_rdata,
    input  logic [LANES*WORD-1:0]    am_src1_rdata,
    output rosetta_pkg::stage_ctx_t  ctx_com,
    output logic [LANES-1:0]         lane_sel_com,
    output logic [LANES*WORD-1:0]    result,
    output logic [LANES-1:0]         nz_mask
);

    rosetta_pkg::stage_ctx_t ctx_rm;
    logic [LANES-1:0]        lane_sel_rm;
    logic [LANES*WORD-1:0]   opnd0_rm;
    logic [LANES*WORD-1:0]   opnd1_rm;
    logic [LANES*WORD-1:0]   lane_y;

    // --------------------------------------------------
    // RM
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        opnd0_rm <= am_src0_rdata;
        opnd1_rm <= am_src1_rdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctx_rm      <= '0;
            lane_sel_rm <= '0;
        end else begin
            ctx_rm      <= ctx_msk;
            lane_sel_rm <= lane_sel_msk;
        end
    end

    // --------------------------------------------------
    // COM
    // --------------------------------------------------
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        rosetta_lane_alu #(
            .WORD (WORD)
        ) u_lane_alu (
            .a        (opnd0_rm[i*WORD +: WORD]),
            .b        (opnd1_rm[i*WORD +: WORD]),
            .op       (ctx_rm.op),
            .fp_shift (ctx_rm.fp_shift),
            .y        (lane_y[i*WORD +: WORD])
        );
    end

    // Deselected lanes carry zero
    always_ff @(posedge clk) begin
        for (int i = 0; i < LANES; i++) begin
            result[i*WORD +: WORD] <= lane_sel_rm[i] ? lane_y[i*WORD +: WORD] : '0;
            nz_mask[i]             <= lane_sel_rm[i] & (|lane_y[i*WORD +: WORD]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctx_com      <= '0;
            lane_sel_com <= '0;
        end else begin
            ctx_com      <= ctx_rm;
            lane_sel_com <= lane_sel_rm;
        end
    end

endmodule
